// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = icache_tb
FILELIST  = verilog.f

.PHONY: sim clean

# Pass only when the simulation output holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== bench/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    localparam int    CLK_PERIOD     = 4;
    localparam int    MAX_REQUESTS   = 400;
    localparam int    WORST_CYCLES   = 40;
    localparam int    RANDOM_FETCHES = 300;
    localparam addr_t SET_STRIDE     = 32'h200;

    typedef enum logic [1:0] {
        any_e,
        hit_e,
        miss_e
    } outcome_t;

    logic  clk;
    logic  reset;
    logic  cpu_read;
    addr_t cpu_addr;
    logic  cpu_resp;
    word_t cpu_data;
    logic  mem_read;
    addr_t mem_addr;
    logic  mem_rvalid;
    beat_t mem_rdata;

    // Request in flight and what it should do
    logic     busy;
    addr_t    req_addr;
    outcome_t expect_kind;

    icache_top #(.SETS(16)) icache_top_i (
        .clk        (clk),
        .reset      (reset),
        .cpu_read   (cpu_read),
        .cpu_addr   (cpu_addr),
        .cpu_resp   (cpu_resp),
        .cpu_data   (cpu_data),
        .mem_read   (mem_read),
        .mem_addr   (mem_addr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    function automatic word_t mem_word(input addr_t a);
        return a * 32'h9e3779b1 + a;
    endfunction

    // Low half at base + 8k, high half at base + 8k + 4
    function automatic beat_t mem_beat(input addr_t base, input int k);
        addr_t lo;
        lo = base + addr_t'(8 * k);
        return {mem_word(lo + 32'h4), mem_word(lo)};
    endfunction

    function automatic addr_t line_base(input addr_t a);
        return {a[31:5], 5'b0};
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[FAIL] t=%0t %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // Quiet with no request, right after reset too
    assert property (@(posedge clk) disable iff (reset)
        !busy |-> !cpu_resp && !mem_read)
        else report_mismatch("response or memory read with no request");

    assert property (@(posedge clk) disable iff (reset)
        cpu_resp |-> cpu_data == mem_word(req_addr))
        else report_mismatch($sformatf("wrong word for address %h", req_addr));

    assert property (@(posedge clk) disable iff (reset)
        mem_read |-> mem_addr == line_base(req_addr))
        else report_mismatch($sformatf("memory address not line base of %h", req_addr));

    assert property (@(posedge clk) disable iff (reset)
        mem_read |-> expect_kind != hit_e)
        else report_mismatch($sformatf("memory read on resident line %h", req_addr));

    // A hit answers in the cycle after the strobe
    assert property (@(posedge clk) disable iff (reset)
        cpu_read && expect_kind == hit_e |=> cpu_resp)
        else report_mismatch($sformatf("late hit response for %h", req_addr));

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(MAX_REQUESTS * WORST_CYCLES * CLK_PERIOD);
        $display("Timeout: the fetch sequence did not finish in time");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    // Called 1 ns after a rising edge, returns 1 ns after one
    task automatic fetch(input addr_t a, input outcome_t kind);
        logic saw_miss;
        saw_miss    = 1'b0;
        req_addr    = a;
        expect_kind = kind;
        busy        = 1'b1;
        cpu_addr    = a;
        cpu_read    = 1'b1;
        @(posedge clk);
        #1;
        cpu_read = 1'b0;
        while (!cpu_resp) begin
            if (mem_read) begin
                saw_miss = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        if (kind == miss_e) begin
            assert (saw_miss)
                else report_mismatch($sformatf("no refill for new line %h", a));
        end
        @(posedge clk);
        #1;
        busy = 1'b0;
    endtask

    // Four beats per mem_read, 0 to 3 idle cycles before each
    initial begin : memory_model
        addr_t base;
        int    gap;
        forever begin
            @(posedge clk);
            #1;
            if (mem_read) begin
                base = mem_addr;
                for (int k = 0; k < LINE_BEATS; k++) begin
                    gap = int'($urandom_range(3, 0));
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                    mem_rvalid = 1'b1;
                    mem_rdata  = mem_beat(base, k);
                    @(posedge clk);
                    #1;
                    mem_rvalid = 1'b0;
                end
            end
        end
    end

    initial begin : stimulus
        addr_t       a_set;
        addr_t       b_set;
        addr_t       a;
        int unsigned line_no;
        int unsigned word_no;
        void'($urandom(32'hbb71));
        reset       = 1'b1;
        cpu_read    = 1'b0;
        cpu_addr    = '0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        busy        = 1'b0;
        req_addr    = '0;
        expect_kind = any_e;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (5) begin
            @(posedge clk);
            #1;
        end

        // Cold misses, then other words of the same lines
        fetch(32'h0000_1024, miss_e);
        fetch(32'h0000_103c, hit_e);
        fetch(32'h0000_1020, hit_e);
        fetch(32'h0000_1030, hit_e);
        fetch(32'h0000_2048, miss_e);
        fetch(32'h0000_2044, hit_e);

        // Set 3: A to D fill all ways, E pushes out A
        a_set = 32'h0001_0060;
        for (int i = 0; i < 5; i++) begin
            fetch(a_set + SET_STRIDE * addr_t'(i) + addr_t'(4 * i), miss_e);
        end
        for (int i = 1; i < 4; i++) begin
            fetch(a_set + SET_STRIDE * addr_t'(i), hit_e);
        end
        fetch(a_set, miss_e);

        // Set 5: A used again before E, so B goes
        b_set = 32'h0002_00a0;
        for (int i = 0; i < 4; i++) begin
            fetch(b_set + SET_STRIDE * addr_t'(i), miss_e);
        end
        fetch(b_set + 32'h8, hit_e);
        fetch(b_set + SET_STRIDE * 4, miss_e);
        fetch(b_set, hit_e);
        fetch(b_set + SET_STRIDE * 2, hit_e);
        fetch(b_set + SET_STRIDE * 3, hit_e);
        fetch(b_set + SET_STRIDE, miss_e);

        // 64 lines crowded into four sets
        for (int n = 0; n < RANDOM_FETCHES; n++) begin
            line_no = $urandom_range(63, 0);
            word_no = $urandom_range(7, 0);
            a = 32'h0004_0000 + addr_t'(line_no) * 32'h80 + addr_t'(word_no) * 32'h4;
            fetch(a, any_e);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/icache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_control (
    input  logic               clk,
    input  logic               reset,
    input  logic               cpu_read,
    input  logic               hit,
    input  logic               last_beat,
    output icache_pkg::state_t state,
    output logic               addr_we,
    output logic               mem_read,
    output logic               cpu_resp
);
    import icache_pkg::*;

    state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle_s;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        addr_we    = 1'b0;
        mem_read   = 1'b0;
        cpu_resp   = 1'b0;
        case (state)
            idle_s: begin
                // Strobes outside idle are dropped
                if (cpu_read) begin
                    addr_we    = 1'b1;
                    next_state = compare_s;
                end
            end
            compare_s: begin
                if (hit) begin
                    cpu_resp   = 1'b1;
                    next_state = idle_s;
                end else begin
                    next_state = refill_s;
                end
            end
            refill_s: begin
                mem_read = 1'b1;
                if (last_beat) begin
                    next_state = allocate_s;
                end
            end
            allocate_s: begin
                // Line is written this cycle
                next_state = compare_s;
            end
            default: begin
                next_state = idle_s;
            end
        endcase
    end

    // Refilled line is visible to the compare that follows
    assert property (@(posedge clk) disable iff (reset)
        state == allocate_s |=> state == compare_s && hit)
        else $error("allocate not followed by a hit in compare");

endmodule

`default_nettype wire

// ==== logic/icache_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_datapath #(
    parameter int SETS = 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  icache_pkg::state_t      state,
    input  logic                    addr_we,
    input  icache_pkg::addr_t       cpu_addr,
    input  icache_pkg::lookup_t     lookup [icache_pkg::WAYS],
    input  icache_pkg::line_t       lines  [icache_pkg::WAYS],
    input  icache_pkg::line_t       refill_line,
    input  icache_pkg::way_t        victim,
    output logic                    hit,
    output logic [$clog2(SETS)-1:0] index,
    output logic                    touch,
    output icache_pkg::way_t        touch_way,
    output icache_pkg::fill_t       fill,
    output logic                    fill_we,
    output icache_pkg::word_t       cpu_data,
    output icache_pkg::addr_t       mem_addr
);
    import icache_pkg::*;

    localparam int IDX_W    = $clog2(SETS);
    localparam int OFFSET_W = $bits(offset_t);
    localparam int TAG_LSB  = OFFSET_W + IDX_W;
    localparam int WORD_W   = $bits(word_t);

    addr_t           req_addr;
    tag_t            req_tag;
    offset_t         req_offset;
    logic [IDX_W-1:0] req_index;
    logic [WAYS-1:0] match;
    way_t            hit_way;
    way_t            victim_q;
    line_t           hit_line;

    always_ff @(posedge clk) begin
        if (addr_we) begin
            req_addr <= cpu_addr;
        end
    end

    assign req_tag    = tag_t'(req_addr >> TAG_LSB);
    assign req_offset = req_addr[OFFSET_W-1:0];
    assign req_index  = req_addr[OFFSET_W +: IDX_W];

    // Ways read from the live address only in idle
    assign index = (state == idle_s) ? cpu_addr[OFFSET_W +: IDX_W] : req_index;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            match[w] = lookup[w].valid && (lookup[w].tag == req_tag);
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = |match;

    assign hit_line = lines[hit_way];
    assign cpu_data = hit_line[{req_offset[OFFSET_W-1:2], 5'b0} +: WORD_W];

    // Victim fixed at the miss, the tree may move before allocate
    always_ff @(posedge clk) begin
        if (state == compare_s && !hit) begin
            victim_q <= victim;
        end
    end

    assign touch     = (state == compare_s && hit) || (state == allocate_s);
    assign touch_way = (state == allocate_s) ? victim_q : hit_way;

    assign fill.way   = victim_q;
    assign fill.index = set_t'(req_index);
    assign fill.tag   = req_tag;
    assign fill.line  = refill_line;
    assign fill_we    = (state == allocate_s);

    assign mem_addr = {req_addr[$bits(addr_t)-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // Fills only go to the victim, so a tag never sits in two ways
    assert property (@(posedge clk) disable iff (reset)
        state == compare_s |-> $onehot0(match))
        else $error("more than one way matches");

endmodule

`default_nettype wire

// ==== logic/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    localparam int WAYS = 4;
    localparam int LINE_BEATS = 4;

    typedef logic [31:0] addr_t;
    // Address bits 31 to 9 with 16 sets
    typedef logic [22:0] tag_t;
    typedef logic [4:0] offset_t;
    // Room for up to 256 sets
    typedef logic [7:0] set_t;
    typedef logic [31:0] word_t;
    typedef logic [255:0] line_t;
    typedef logic [63:0] beat_t;
    typedef logic [1:0] way_t;
    typedef logic [2:0] plru_t;
    typedef logic [1:0] beat_count_t;

    typedef enum logic [1:0] {
        idle_s,
        compare_s,
        refill_s,
        allocate_s
    } state_t;

    typedef struct packed {
        tag_t tag;
        logic valid;
    } lookup_t;

    typedef struct packed {
        way_t  way;
        set_t  index;
        tag_t  tag;
        line_t line;
    } fill_t;

endpackage

`default_nettype wire

// ==== logic/icache_plru.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_plru #(
    parameter int SETS = 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [$clog2(SETS)-1:0] index,
    input  logic                    touch,
    input  icache_pkg::way_t        touch_way,
    output icache_pkg::way_t        victim
);
    import icache_pkg::*;

    plru_t tree [SETS];
    plru_t cur;
    plru_t updated;

    assign cur = tree[index];

    // Bit 0 picks the half, bit 1 covers ways 0/1, bit 2 ways 2/3
    always_comb begin
        updated    = cur;
        updated[0] = ~touch_way[1];
        if (touch_way[1]) begin
            updated[2] = ~touch_way[0];
        end else begin
            updated[1] = ~touch_way[0];
        end
    end

    // Follow the bits down to a leaf
    always_comb begin
        if (cur[0]) begin
            victim = {1'b1, cur[2]};
        end else begin
            victim = {1'b0, cur[1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[index] <= updated;
        end
    end

endmodule

`default_nettype wire

// ==== logic/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter int SETS = 16
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              cpu_read,
    input  icache_pkg::addr_t cpu_addr,
    output logic              cpu_resp,
    output icache_pkg::word_t cpu_data,
    output logic              mem_read,
    output icache_pkg::addr_t mem_addr,
    input  logic              mem_rvalid,
    input  icache_pkg::beat_t mem_rdata
);
    import icache_pkg::*;

    state_t           state;
    logic             hit;
    logic             last_beat;
    logic             addr_we;
    line_t            refill_line;
    logic [$clog2(SETS)-1:0] index;
    lookup_t          lookup [WAYS];
    line_t            lines  [WAYS];
    fill_t            fill;
    logic             fill_we;
    logic             touch;
    way_t             touch_way;
    way_t             victim;

    icache_control icache_control_i (
        .clk       (clk),
        .reset     (reset),
        .cpu_read  (cpu_read),
        .hit       (hit),
        .last_beat (last_beat),
        .state     (state),
        .addr_we   (addr_we),
        .mem_read  (mem_read),
        .cpu_resp  (cpu_resp)
    );

    refill_counter refill_counter_i (
        .clk        (clk),
        .reset      (reset),
        .state      (state),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .line       (refill_line),
        .last_beat  (last_beat)
    );

    icache_ways #(.SETS(SETS)) icache_ways_i (
        .clk     (clk),
        .reset   (reset),
        .index   (index),
        .fill    (fill),
        .fill_we (fill_we),
        .lookup  (lookup),
        .lines   (lines)
    );

    icache_plru #(.SETS(SETS)) icache_plru_i (
        .clk       (clk),
        .reset     (reset),
        .index     (index),
        .touch     (touch),
        .touch_way (touch_way),
        .victim    (victim)
    );

    icache_datapath #(.SETS(SETS)) icache_datapath_i (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .addr_we     (addr_we),
        .cpu_addr    (cpu_addr),
        .lookup      (lookup),
        .lines       (lines),
        .refill_line (refill_line),
        .victim      (victim),
        .hit         (hit),
        .index       (index),
        .touch       (touch),
        .touch_way   (touch_way),
        .fill        (fill),
        .fill_we     (fill_we),
        .cpu_data    (cpu_data),
        .mem_addr    (mem_addr)
    );

endmodule

`default_nettype wire

// ==== logic/icache_ways.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ways #(
    parameter int SETS = 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [$clog2(SETS)-1:0] index,
    input  icache_pkg::fill_t       fill,
    input  logic                    fill_we,
    output icache_pkg::lookup_t     lookup [icache_pkg::WAYS],
    output icache_pkg::line_t       lines  [icache_pkg::WAYS]
);
    import icache_pkg::*;

    localparam int IDX_W = $clog2(SETS);

    tag_t            tags  [SETS][WAYS];
    line_t           data  [SETS][WAYS];
    logic [WAYS-1:0] valid [SETS];
    logic [IDX_W-1:0] fill_index;

    assign fill_index = fill.index[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (fill_we) begin
            valid[fill_index][fill.way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tags[fill_index][fill.way] <= fill.tag;
            data[fill_index][fill.way] <= fill.line;
        end
    end

    // Registered read; a fill to the read set is forwarded
    // so compare right after allocate sees the new line
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (fill_we && fill_index == index && fill.way == way_t'(w)) begin
                lookup[w].tag   <= fill.tag;
                lookup[w].valid <= 1'b1;
                lines[w]        <= fill.line;
            end else begin
                lookup[w].tag   <= tags[index][w];
                lookup[w].valid <= valid[index][w];
                lines[w]        <= data[index][w];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/refill_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_counter (
    input  logic               clk,
    input  logic               reset,
    input  icache_pkg::state_t state,
    input  logic               mem_rvalid,
    input  icache_pkg::beat_t  mem_rdata,
    output icache_pkg::line_t  line,
    output logic               last_beat
);
    import icache_pkg::*;

    localparam int BEAT_W = $bits(beat_t);

    beat_count_t count;
    logic        take;

    assign take      = (state == refill_s) && mem_rvalid;
    assign last_beat = take && (count == beat_count_t'(LINE_BEATS - 1));

    always_ff @(posedge clk) begin
        if (reset || state != refill_s) begin
            count <= '0;
        end else if (mem_rvalid) begin
            count <= count + beat_count_t'(1);
        end
    end

    // Beat k fills bits 64k up
    always_ff @(posedge clk) begin
        if (take) begin
            line[count * BEAT_W +: BEAT_W] <= mem_rdata;
        end
    end

    // Memory only answers an open refill
    assert property (@(posedge clk) disable iff (reset)
        mem_rvalid |-> state == refill_s)
        else $error("mem_rvalid outside refill");

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/icache_pkg.sv
logic/icache_control.sv
logic/refill_counter.sv
logic/icache_ways.sv
logic/icache_plru.sv
logic/icache_datapath.sv
logic/icache_top.sv
bench/icache_tb.sv
